// File: Bender.yml
package:
  name: arm_core

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/armPkg.sv
      - hdl/armDecoder.sv
      - hdl/armCondLogic.sv
      - hdl/armRegFile.sv
      - hdl/armAlu.sv
      - hdl/armDatapath.sv
      - hdl/armCore.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/armCoreTb.sv

// File: build.f
+incdir+hdl
hdl/armPkg.sv
hdl/armDecoder.sv
hdl/armCondLogic.sv
hdl/armRegFile.sv
hdl/armAlu.sv
hdl/armDatapath.sv
hdl/armCore.sv
verif/armCoreTb.sv

// File: hdl/armAlu.sv
`timescale 1ns/100ps
`include "arm_consts.svh"

module armAlu
(
   input  armPkg::wordT  SrcA,
   input  armPkg::wordT  SrcB,
   input  armPkg::aluOpT ALUOp,
   output armPkg::wordT  Result,
   output armPkg::flagsT ALUFlags
);

   logic             isSub;
   logic             isArith;
   armPkg::wordT     condInvB;           // B or ~B for subtract
   logic [`ARM_XLEN:0] sum;              // Carry in the top bit

   assign isSub    = (ALUOp == armPkg::aluSub);
   assign isArith  = (ALUOp == armPkg::aluAdd) || isSub;
   assign condInvB = isSub ? ~SrcB : SrcB;

   // A - B as A + ~B + 1
   assign sum = {1'b0, SrcA} + {1'b0, condInvB} + {{`ARM_XLEN{1'b0}}, isSub};

   always_comb
   begin
      case (ALUOp)
         armPkg::aluAnd: Result = SrcA & SrcB;
         armPkg::aluOr:  Result = SrcA | SrcB;
         default:        Result = sum[`ARM_XLEN-1:0];
      endcase
   end

   assign ALUFlags.n = Result[`ARM_XLEN-1];
   assign ALUFlags.z = (Result == '0);
   assign ALUFlags.c = isArith & sum[`ARM_XLEN];
   // Overflow when operands agree in sign and the sum does not
   assign ALUFlags.v = isArith
                       & ~(SrcA[`ARM_XLEN-1] ^ SrcB[`ARM_XLEN-1] ^ isSub)
                       & (SrcA[`ARM_XLEN-1] ^ sum[`ARM_XLEN-1]);

endmodule

// File: hdl/armCondLogic.sv
`timescale 1ns/100ps

module armCondLogic
(
   input  logic          clk,
   input  logic          reset,
   input  armPkg::condT  Cond,
   input  armPkg::flagsT ALUFlags,
   input  logic [1:0]    FlagW,
   input  logic          PCS,
   input  logic          RegW,
   input  logic          MemW,
   input  logic          MemAcc,
   input  logic          PCReady,
   output logic          PCSrc,
   output logic          RegWrite,
   output logic          MemWrite,
   output logic          MemStrobe
);

   armPkg::flagsT flags;            // Stored N/Z/C/V
   logic          condEx;
   logic          commit;           // Condition passed and not stalled
   logic [1:0]    flagWrite;
   logic          ge;

   assign ge = (flags.n == flags.v);

   // Condition evaluation
   always_comb
   begin
      case (Cond)
         armPkg::condEq: condEx = flags.z;
         armPkg::condNe: condEx = ~flags.z;
         armPkg::condCs: condEx = flags.c;
         armPkg::condCc: condEx = ~flags.c;
         armPkg::condMi: condEx = flags.n;
         armPkg::condPl: condEx = ~flags.n;
         armPkg::condVs: condEx = flags.v;
         armPkg::condVc: condEx = ~flags.v;
         armPkg::condHi: condEx = flags.c & ~flags.z;
         armPkg::condLs: condEx = ~flags.c | flags.z;
         armPkg::condGe: condEx = ge;
         armPkg::condLt: condEx = ~ge;
         armPkg::condGt: condEx = ~flags.z & ge;
         armPkg::condLe: condEx = flags.z | ~ge;
         armPkg::condAl: condEx = 1'b1;
         default:        condEx = 1'b0;  // 1111 never executes
      endcase
   end

   // A stall blocks every architectural write
   assign commit    = condEx & PCReady;
   assign flagWrite = FlagW & {2{commit}};

   // Flag register, two halves
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         flags <= '0;
      else
      begin
         if (flagWrite[1])
            {flags.n, flags.z} <= {ALUFlags.n, ALUFlags.z};
         if (flagWrite[0])
            {flags.c, flags.v} <= {ALUFlags.c, ALUFlags.v};
      end
   end

   assign PCSrc     = PCS & commit;
   assign RegWrite  = RegW & commit;
   assign MemWrite  = MemW & commit;
   assign MemStrobe = MemAcc & commit;  // Access marker for the memory

endmodule

// File: hdl/armCore.sv
`timescale 1ns/100ps
`include "arm_consts.svh"

module armCore
(
   input  logic         clk,
   input  logic         reset,
   input  armPkg::wordT Instr,
   input  armPkg::wordT ReadData,
   input  logic         PCReady,
   output armPkg::wordT PC,
   output logic         MemWrite,
   output logic         MemStrobe,
   output armPkg::wordT ALUResult,         // Data address
   output armPkg::wordT WriteData
);

   // Raw controls before the condition check
   logic [1:0]     flagW;
   logic           pcs;
   logic           regW;
   logic           memW;
   logic           memAcc;

   // Datapath controls
   logic           memtoReg;
   logic           aluSrc;
   armPkg::immSrcT immSrc;
   armPkg::aluOpT  aluOp;
   logic [1:0]     regSrc;

   // Gated controls and feedback
   logic           pcSrc;
   logic           regWrite;
   armPkg::flagsT  aluFlags;

   armDecoder decoder (
      .Instr    (Instr),
      .FlagW    (flagW),
      .PCS      (pcs),
      .RegW     (regW),
      .MemW     (memW),
      .MemAcc   (memAcc),
      .MemtoReg (memtoReg),
      .ALUSrc   (aluSrc),
      .ImmSrc   (immSrc),
      .ALUOp    (aluOp),
      .RegSrc   (regSrc)
   );

   armCondLogic condLogic (
      .clk       (clk),
      .reset     (reset),
      .Cond      (armPkg::condT'(Instr[`ARM_COND_HI:`ARM_COND_LO])),  // Condition field
      .ALUFlags  (aluFlags),
      .FlagW     (flagW),
      .PCS       (pcs),
      .RegW      (regW),
      .MemW      (memW),
      .MemAcc    (memAcc),
      .PCReady   (PCReady),
      .PCSrc     (pcSrc),
      .RegWrite  (regWrite),
      .MemWrite  (MemWrite),
      .MemStrobe (MemStrobe)
   );

   armDatapath datapath (
      .clk       (clk),
      .reset     (reset),
      .Instr     (Instr),
      .ReadData  (ReadData),
      .PCReady   (PCReady),
      .PCSrc     (pcSrc),
      .RegWrite  (regWrite),
      .MemtoReg  (memtoReg),
      .ALUSrc    (aluSrc),
      .ImmSrc    (immSrc),
      .ALUOp     (aluOp),
      .RegSrc    (regSrc),
      .ALUFlags  (aluFlags),
      .PC        (PC),
      .ALUResult (ALUResult),
      .WriteData (WriteData)
   );

endmodule

// File: hdl/armDatapath.sv
`timescale 1ns/100ps
`include "arm_consts.svh"

module armDatapath
(
   input  logic           clk,
   input  logic           reset,
   input  armPkg::wordT   Instr,
   input  armPkg::wordT   ReadData,
   input  logic           PCReady,
   input  logic           PCSrc,
   input  logic           RegWrite,
   input  logic           MemtoReg,
   input  logic           ALUSrc,
   input  armPkg::immSrcT ImmSrc,
   input  armPkg::aluOpT  ALUOp,
   input  logic [1:0]     RegSrc,
   output armPkg::flagsT  ALUFlags,
   output armPkg::wordT   PC,
   output armPkg::wordT   ALUResult,
   output armPkg::wordT   WriteData
);

   armPkg::wordT    pcNext;
   armPkg::wordT    pcPlus4;
   armPkg::wordT    pcPlus8;
   armPkg::wordT    extImm;
   armPkg::wordT    srcA;
   armPkg::wordT    srcB;
   armPkg::wordT    result;             // Write-back value and jump target
   armPkg::regAddrT ra1;
   armPkg::regAddrT ra2;

   // PC holds while the core is stalled
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         PC <= '0;
      else if (PCReady)
         PC <= pcNext;
   end

   assign pcPlus4 = PC + armPkg::wordT'(`ARM_PC_STEP);
   assign pcPlus8 = pcPlus4 + armPkg::wordT'(`ARM_PC_STEP);
   assign pcNext  = PCSrc ? result : pcPlus4;

   // Read address muxes
   assign ra1 = RegSrc[0] ? armPkg::regAddrT'(`ARM_PC_REG) : Instr[`ARM_RN_HI:`ARM_RN_LO];
   assign ra2 = RegSrc[1] ? Instr[`ARM_RD_HI:`ARM_RD_LO] : Instr[`ARM_RM_HI:`ARM_RM_LO];

   armRegFile regFile (
      .clk        (clk),
      .WriteEn    (RegWrite),
      .ReadAddr1  (ra1),
      .ReadAddr2  (ra2),
      .WriteAddr  (Instr[`ARM_RD_HI:`ARM_RD_LO]),
      .WriteValue (result),
      .PCPlus8    (pcPlus8),
      .ReadValue1 (srcA),
      .ReadValue2 (WriteData)           // Rd for STR, Rm otherwise
   );

   // Immediate extension
   always_comb
   begin
      case (ImmSrc)
         armPkg::imm12:    extImm = {20'b0, Instr[11:0]};
         armPkg::branch24: extImm = {{6{Instr[23]}}, Instr[23:0], 2'b00}; // Word offset
         default:          extImm = {24'b0, Instr[7:0]};
      endcase
   end

   assign srcB = ALUSrc ? extImm : WriteData;

   armAlu alu (
      .SrcA     (srcA),
      .SrcB     (srcB),
      .ALUOp    (ALUOp),
      .Result   (ALUResult),
      .ALUFlags (ALUFlags)
   );

   assign result = MemtoReg ? ReadData : ALUResult;  // LDR takes memory data

endmodule

// File: hdl/armDecoder.sv
`timescale 1ns/100ps
`include "arm_consts.svh"

module armDecoder
(
   input  armPkg::wordT   Instr,
   output logic [1:0]     FlagW,
   output logic           PCS,
   output logic           RegW,
   output logic           MemW,
   output logic           MemAcc,
   output logic           MemtoReg,
   output logic           ALUSrc,
   output armPkg::immSrcT ImmSrc,
   output armPkg::aluOpT  ALUOp,
   output logic [1:0]     RegSrc
);

   logic [1:0]        op;
   logic [5:0]        funct;          // I, function code, S/L
   armPkg::regAddrT   rd;
   logic              branch;
   logic              isArith;

   assign op    = Instr[27:26];
   assign funct = Instr[25:20];
   assign rd    = Instr[`ARM_RD_HI:`ARM_RD_LO];

   // Main decoder
   always_comb
   begin
      // Defaults form a no-op
      RegSrc   = 2'b00;
      ImmSrc   = armPkg::imm8;
      ALUSrc   = 1'b0;
      MemtoReg = 1'b0;
      RegW     = 1'b0;
      MemW     = 1'b0;
      MemAcc   = 1'b0;
      branch   = 1'b0;
      ALUOp    = armPkg::aluAdd;    // Address and target math
      case (op)
         `ARM_OP_DP:
         begin
            ALUSrc = funct[5];      // Immediate form
            RegW   = 1'b1;
            case (funct[4:1])       // ALU decoder
               `ARM_FN_SUB: ALUOp = armPkg::aluSub;
               `ARM_FN_AND: ALUOp = armPkg::aluAnd;
               `ARM_FN_ORR: ALUOp = armPkg::aluOr;
               default:     ALUOp = armPkg::aluAdd;
            endcase
         end
         `ARM_OP_MEM:
         begin
            ImmSrc   = armPkg::imm12;
            ALUSrc   = 1'b1;
            MemAcc   = 1'b1;
            MemtoReg = funct[0];    // L bit
            RegW     = funct[0];
            MemW     = ~funct[0];
            RegSrc   = {~funct[0], 1'b0}; // STR reads Rd on port 2
         end
         `ARM_OP_BR:
         begin
            ImmSrc = armPkg::branch24;
            ALUSrc = 1'b1;
            RegSrc = 2'b01;         // Base is R15, i.e. PC+8
            branch = 1'b1;
         end
         default: ;                 // Op 11 does nothing
      endcase
   end

   // C and V only follow the arithmetic ops
   assign isArith  = (ALUOp == armPkg::aluAdd) || (ALUOp == armPkg::aluSub);
   assign FlagW[1] = (op == `ARM_OP_DP) & funct[0];        // N, Z
   assign FlagW[0] = (op == `ARM_OP_DP) & funct[0] & isArith; // C, V

   // Jump on branch or on any write to R15
   assign PCS = branch | (RegW & (rd == armPkg::regAddrT'(`ARM_PC_REG)));

endmodule

// File: hdl/armPkg.sv
`include "arm_consts.svh"

package armPkg;

   // Data word and address
   typedef logic [`ARM_XLEN-1:0] wordT;

   // Register number, 0..15
   typedef logic [$clog2(`ARM_NREGS)-1:0] regAddrT;

   // Status flags, N at the top bit
   typedef struct packed {
      logic n;                      // Negative
      logic z;                      // Zero
      logic c;                      // Carry out
      logic v;                      // Signed overflow
   } flagsT;

   // Condition field, code 1111 left out and read as never
   typedef enum logic [3:0] {
      condEq = 4'b0000,             // Z set
      condNe,                       // Z clear
      condCs,                       // C set
      condCc,                       // C clear
      condMi,                       // N set
      condPl,                       // N clear
      condVs,                       // V set
      condVc,                       // V clear
      condHi,                       // Unsigned higher
      condLs,                       // Unsigned lower or same
      condGe,                       // Signed greater or equal
      condLt,                       // Signed less
      condGt,                       // Signed greater
      condLe,                       // Signed less or equal
      condAl                        // Always
   } condT;

   // ALU operations
   typedef enum logic [1:0] {
      aluAdd = 2'b00,
      aluSub = 2'b01,
      aluAnd = 2'b10,
      aluOr  = 2'b11
   } aluOpT;

   // Immediate kinds for the extender
   typedef enum logic [1:0] {
      imm8     = 2'b00,             // Zero-extended byte
      imm12    = 2'b01,             // Zero-extended memory offset
      branch24 = 2'b10              // Sign-extended word offset
   } immSrcT;

endpackage

// File: hdl/armRegFile.sv
`timescale 1ns/100ps
`include "arm_consts.svh"

module armRegFile
(
   input  logic            clk,
   input  logic            WriteEn,
   input  armPkg::regAddrT ReadAddr1,
   input  armPkg::regAddrT ReadAddr2,
   input  armPkg::regAddrT WriteAddr,
   input  armPkg::wordT    WriteValue,
   input  armPkg::wordT    PCPlus8,
   output armPkg::wordT    ReadValue1,
   output armPkg::wordT    ReadValue2
);

   localparam armPkg::regAddrT PcIdx = armPkg::regAddrT'(`ARM_PC_REG);

   armPkg::wordT regs [`ARM_NREGS-2:0];  // R0..R14, R15 lives in the PC

   // R15 writes go to the PC, not here
   always_ff @(posedge clk)
   begin
      if (WriteEn && (WriteAddr != PcIdx))
         regs[WriteAddr] <= WriteValue;
   end

   // Combinational reads, R15 gives PC+8
   assign ReadValue1 = (ReadAddr1 == PcIdx) ? PCPlus8 : regs[ReadAddr1];
   assign ReadValue2 = (ReadAddr2 == PcIdx) ? PCPlus8 : regs[ReadAddr2];

endmodule

// File: hdl/arm_consts.svh
`ifndef ARM_CONSTS_SVH
`define ARM_CONSTS_SVH

// Machine widths
`define ARM_XLEN     32          // Data and address width
`define ARM_NREGS    16          // Architectural registers incl. R15

// Program counter
`define ARM_PC_REG   15          // R15 index
`define ARM_PC_STEP  4           // Bytes per instruction

// Op field, Instr[27:26]
`define ARM_OP_DP    2'b00       // Data processing
`define ARM_OP_MEM   2'b01       // LDR / STR
`define ARM_OP_BR    2'b10       // B

// Function codes of data processing, Instr[24:21]
`define ARM_FN_AND   4'b0000
`define ARM_FN_SUB   4'b0010
`define ARM_FN_ADD   4'b0100
`define ARM_FN_ORR   4'b1100

// Instruction field positions
`define ARM_COND_HI  31
`define ARM_COND_LO  28
`define ARM_RN_HI    19
`define ARM_RN_LO    16
`define ARM_RD_HI    15
`define ARM_RD_LO    12
`define ARM_RM_HI    3
`define ARM_RM_LO    0

`endif

// File: verif/armCoreTb.sv
`timescale 1ns/100ps
`include "arm_consts.svh"

module armCoreTb;

   localparam int memWords   = 256;             // Program and data depth
   localparam int progWords  = 240;             // Generated instructions
   localparam int maxCycles  = 3000;            // Run loop limit
   localparam armPkg::wordT endAddr = progWords * `ARM_PC_STEP;
   localparam logic [3:0] condAlways = 4'hE;

   logic         clk;
   logic         reset;
   logic         PCReady;
   armPkg::wordT Instr;
   armPkg::wordT ReadData;
   armPkg::wordT PC;
   logic         MemWrite;
   logic         MemStrobe;
   armPkg::wordT ALUResult;
   armPkg::wordT WriteData;

   armPkg::wordT progMem [0:memWords-1];
   armPkg::wordT dataMem [0:memWords-1];    // Memory seen by the DUT

   // Model state
   armPkg::wordT  refRegs [0:14];
   armPkg::flagsT refFlags;
   armPkg::wordT  refPc;
   armPkg::wordT  refMem [0:memWords-1];

   // Predicted outputs of the current cycle
   armPkg::wordT expAluResult;
   armPkg::wordT expWriteData;
   logic         expMemWrite;
   logic         expMemStrobe;
   logic         expStore;                  // WriteData only checked for STR

   armPkg::wordT rngState;
   logic         running;
   logic         done;
   int           stallCount;
   int           loadCount;
   int           storeCount;
   int           branchCount;
   int           skipCount;

   armCore uut (
      .clk       (clk),
      .reset     (reset),
      .Instr     (Instr),
      .ReadData  (ReadData),
      .PCReady   (PCReady),
      .PC        (PC),
      .MemWrite  (MemWrite),
      .MemStrobe (MemStrobe),
      .ALUResult (ALUResult),
      .WriteData (WriteData)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;                // 4 ns period
   end

   // Word-addressed combinational memories
   assign Instr    = progMem[PC[9:2]];
   assign ReadData = dataMem[ALUResult[9:2]];

   always @(posedge clk)
   begin
      if (MemWrite)
         dataMem[ALUResult[9:2]] <= WriteData;
   end

   task automatic failRun(input string why);
      $display("%s", why);
      $display("Checks failed");
      $fatal(1);
   endtask

   task automatic checkWord(input string name, input armPkg::wordT got, input armPkg::wordT exp);
      if (got !== exp)
         failRun($sformatf("error %s: got 0x%08h, expected 0x%08h", name, got, exp));
   endtask

   task automatic checkBit(input string name, input logic got, input logic exp);
      if (got !== exp)
         failRun($sformatf("error %s: got 0x%0h, expected 0x%0h", name, got, exp));
   endtask

   function automatic armPkg::wordT xorshift(input armPkg::wordT x);
      armPkg::wordT y;
      y = x;
      y = y ^ (y << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic armPkg::wordT drawRandom();
      rngState = xorshift(rngState);
      return rngState;
   endfunction

   // Mixes every bit of the index
   function automatic armPkg::wordT fillWord(input int i);
      return (armPkg::wordT'(i) * 32'h9E3779B9) ^ 32'h5A5A0000 ^ armPkg::wordT'(i);
   endfunction

   function automatic armPkg::wordT encodeDp(input logic [3:0] cond, input logic immForm,
                                             input logic [3:0] fn, input logic setFlags,
                                             input armPkg::regAddrT rn, input armPkg::regAddrT rd,
                                             input logic [11:0] src2);
      return {cond, `ARM_OP_DP, immForm, fn, setFlags, rn, rd, src2};
   endfunction

   // Pre-indexed offset without writeback
   function automatic armPkg::wordT encodeMem(input logic [3:0] cond, input logic load,
                                              input armPkg::regAddrT rn,
                                              input armPkg::regAddrT rd,
                                              input logic [11:0] offset);
      return {cond, `ARM_OP_MEM, 5'b01100, load, rn, rd, offset};
   endfunction

   function automatic armPkg::wordT encodeBranch(input logic [3:0] cond, input logic [23:0] off);
      return {cond, `ARM_OP_BR, 2'b10, off};
   endfunction

   // Mostly AL with the odd random code incl. never
   function automatic logic [3:0] pickCond();
      armPkg::wordT r;
      r = drawRandom();
      return (r[1:0] == 2'b00) ? r[7:4] : condAlways;
   endfunction

   // R13 kept as memory base and R15 left to jumps
   function automatic armPkg::regAddrT pickDest();
      armPkg::wordT r;
      r = drawRandom() % 14;
      return (r == 13) ? armPkg::regAddrT'(14) : armPkg::regAddrT'(r);
   endfunction

   function automatic armPkg::wordT randomDp();
      armPkg::wordT    r;
      logic [3:0]      fn;
      logic [3:0]      cond;
      armPkg::regAddrT rd;
      r    = drawRandom();
      cond = pickCond();
      rd   = pickDest();
      case (r[1:0])
         2'd0:    fn = `ARM_FN_ADD;
         2'd1:    fn = `ARM_FN_SUB;
         2'd2:    fn = `ARM_FN_AND;
         default: fn = `ARM_FN_ORR;
      endcase
      return encodeDp(cond, r[2], fn, r[3], armPkg::regAddrT'(r[7:4]), rd,
                      r[2] ? {4'b0, r[15:8]} : {8'b0, r[19:16]});
   endfunction

   task automatic buildProgram();
      int              idx;
      int              r;
      armPkg::wordT    rnd;
      logic [3:0]      cond;
      armPkg::regAddrT rd;
      idx = 0;
      // Each register cleared then seeded
      for (r = 0; r < 15; r++)
      begin
         rnd = drawRandom();
         progMem[idx] = encodeDp(condAlways, 1'b1, `ARM_FN_AND, 1'b0, 4'd15,
                                 armPkg::regAddrT'(r), 12'h000);
         progMem[idx+1] = encodeDp(condAlways, 1'b1, `ARM_FN_ORR, 1'b0, armPkg::regAddrT'(r),
                                   armPkg::regAddrT'(r), {4'b0, (r == 13) ? 8'h80 : rnd[7:0]});
         idx = idx + 2;
      end
      while (idx < progWords)
      begin
         rnd  = drawRandom();
         cond = pickCond();
         rd   = pickDest();
         if (rnd[2:0] == 3'd4)
            progMem[idx] = encodeMem(cond, 1'b1, 4'd13, rd, {4'b0, rnd[13:8], 2'b00}); // LDR
         else if (rnd[2:0] == 3'd5)
            progMem[idx] = encodeMem(cond, 1'b0, 4'd13, rnd[19:16], {4'b0, rnd[13:8], 2'b00});
         else if (rnd[2:0] == 3'd6 && idx < progWords - 8)
            progMem[idx] = encodeBranch(cond, {22'b0, rnd[9:8]}); // Forward B
         else if (rnd[2:0] == 3'd7 && idx < progWords - 4)
            progMem[idx] = encodeDp(cond, 1'b1, `ARM_FN_ADD, 1'b0, 4'd15, 4'd15, 12'h004);
         else
            progMem[idx] = randomDp();
         idx++;
      end
      for (r = progWords; r < memWords; r++)
         progMem[r] = 32'hF000_0000;       // Never executes
   endtask

   function automatic logic condPass(input logic [3:0] cond, input armPkg::flagsT f);
      case (cond)
         4'h0:    return f.z;
         4'h1:    return !f.z;
         4'h2:    return f.c;
         4'h3:    return !f.c;
         4'h4:    return f.n;
         4'h5:    return !f.n;
         4'h6:    return f.v;
         4'h7:    return !f.v;
         4'h8:    return f.c && !f.z;
         4'h9:    return !f.c || f.z;
         4'hA:    return f.n == f.v;
         4'hB:    return f.n != f.v;
         4'hC:    return !f.z && (f.n == f.v);
         4'hD:    return f.z || (f.n != f.v);
         4'hE:    return 1'b1;
         default: return 1'b0;
      endcase
   endfunction

   function automatic armPkg::wordT regRead(input armPkg::regAddrT r);
      return (r == 4'd15) ? refPc + 2 * `ARM_PC_STEP : refRegs[r];
   endfunction

   // Predicts this cycle's outputs and commits when ready
   function automatic void refStep(input armPkg::wordT instr, input logic ready);
      logic            pass;
      logic            arith;
      armPkg::regAddrT rn;
      armPkg::regAddrT rd;
      armPkg::wordT    a;
      armPkg::wordT    b;
      armPkg::wordT    res;
      armPkg::wordT    nextPc;
      logic [32:0]     wide;
      armPkg::flagsT   nf;
      pass   = condPass(instr[31:28], refFlags);
      rn     = instr[19:16];
      rd     = instr[15:12];
      nextPc = refPc + `ARM_PC_STEP;
      expMemWrite  = 1'b0;
      expMemStrobe = 1'b0;
      expStore     = 1'b0;
      expWriteData = regRead(rd);
      if (!ready)
         stallCount++;
      else if (!pass)
         skipCount++;
      case (instr[27:26])
         `ARM_OP_DP:
         begin
            a     = regRead(rn);
            b     = instr[25] ? {24'b0, instr[7:0]} : regRead(instr[3:0]);
            arith = 1'b1;
            nf    = refFlags;
            case (instr[24:21])
               `ARM_FN_SUB:
               begin
                  res  = a - b;
                  nf.c = (a >= b);           // Carry means no borrow
                  nf.v = (a[31] != b[31]) && (res[31] != a[31]);
               end
               `ARM_FN_AND:
               begin
                  res   = a & b;
                  arith = 1'b0;
               end
               `ARM_FN_ORR:
               begin
                  res   = a | b;
                  arith = 1'b0;
               end
               default:
               begin
                  wide = {1'b0, a} + {1'b0, b};
                  res  = wide[31:0];
                  nf.c = wide[32];
                  nf.v = (a[31] == b[31]) && (res[31] != a[31]);
               end
            endcase
            nf.n = res[31];
            nf.z = (res == '0);
            expAluResult = res;
            if (pass && ready)
            begin
               if (instr[20])
               begin
                  refFlags.n = nf.n;
                  refFlags.z = nf.z;
                  if (arith)
                  begin
                     refFlags.c = nf.c;
                     refFlags.v = nf.v;
                  end
               end
               if (rd == 4'd15)
                  nextPc = res;             // Jump through R15
               else
                  refRegs[rd] = res;
            end
         end
         `ARM_OP_MEM:
         begin
            res          = regRead(rn) + {20'b0, instr[11:0]};
            expAluResult = res;
            expStore     = !instr[20];
            expMemStrobe = pass && ready;
            expMemWrite  = pass && ready && !instr[20];
            if (pass && ready)
            begin
               if (instr[20])
               begin
                  loadCount++;
                  if (rd == 4'd15)
                     nextPc = refMem[res[9:2]];
                  else
                     refRegs[rd] = refMem[res[9:2]];
               end
               else
               begin
                  storeCount++;
                  refMem[res[9:2]] = regRead(rd);
               end
            end
         end
         default:
         begin
            res = refPc + 2 * `ARM_PC_STEP + {{6{instr[23]}}, instr[23:0], 2'b00};
            expAluResult = res;
            if (pass && ready)
            begin
               branchCount++;
               nextPc = res;
            end
         end
      endcase
      if (ready)
         refPc = nextPc;
   endfunction

   // Outputs are settled at the falling edge
   always @(negedge clk)
   begin
      if (running && !done)
      begin
         checkWord("PC", PC, refPc);
         if (refPc >= endAddr)
            done = 1'b1;                    // Last PC update seen
         else
         begin
            refStep(progMem[refPc[9:2]], PCReady);
            checkWord("ALUResult", ALUResult, expAluResult);
            checkBit("MemWrite", MemWrite, expMemWrite);
            checkBit("MemStrobe", MemStrobe, expMemStrobe);
            if (expStore)
               checkWord("WriteData", WriteData, expWriteData);
         end
      end
   end

   initial
   begin
      int i;
      int cycles;
      reset       = 1'b1;
      PCReady     = 1'b0;
      running     = 1'b0;
      done        = 1'b0;
      rngState    = 32'h188bd04c;
      stallCount  = 0;
      loadCount   = 0;
      storeCount  = 0;
      branchCount = 0;
      skipCount   = 0;
      buildProgram();
      for (i = 0; i < memWords; i++)
      begin
         dataMem[i] = fillWord(i);
         refMem[i]  = fillWord(i);
      end
      for (i = 0; i < 15; i++)
         refRegs[i] = '0;                   // Seeded by the program prologue
      refFlags = '0;
      refPc    = '0;
      repeat (4) @(posedge clk);
      reset   <= 1'b0;
      running <= 1'b1;
      PCReady <= 1'b1;
      cycles = 0;
      while (!done && cycles < maxCycles)
      begin
         @(posedge clk);
         PCReady <= (drawRandom() % 6) != 0;  // Low about one cycle in six
         cycles++;
      end
      if (!done)
         failRun("Timeout: the program end was never reached");
      else if (stallCount == 0 || loadCount == 0 || storeCount == 0 ||
               branchCount == 0 || skipCount == 0)
         failRun("Stimulus missed stalls, loads, stores, branches or failed conditions");
      else
      begin
         $display("%0d cycles, %0d stalls, %0d loads, %0d stores, %0d branches, %0d skipped",
                  cycles, stallCount, loadCount, storeCount, branchCount, skipCount);
         $display("All checks passed");
         $finish;
      end
   end

endmodule
